// File: design/chan_test_cfg.svh
/*
 * Build constants for the message channel test harness.
 * Included by the package and by the RTL that needs a width, an address
 * or the source sequence constant. Edit the values here only.
 */
`ifndef CHAN_TEST_CFG_SVH
`define CHAN_TEST_CFG_SVH

// Message width on both FIFO sides
`define CHAN_WIDTH 64

// Register address that carries the test command
`define CSR_TEST_ADDR 0

// Constant XORed into each step of the SOURCE sequence
`define SRC_MIX 12345

`endif

// File: design/chan_test_pkg.sv
/*
 * Shared types of the channel test harness: the test mode encoding and
 * the structs for register writes, decoded commands and status.
 * Referenced by scoped names from the RTL and the testbench.
 */
`include "chan_test_cfg.svh"

package chan_test_pkg;

    // One message on either FIFO side
    typedef logic [`CHAN_WIDTH-1:0] chan_data_t;

    // Harness mode, also the encoding of wdata[1:0] in a command
    typedef enum logic [1:0]
    {
        NORMAL   = 2'd0,
        SINK     = 2'd1,
        SOURCE   = 2'd2,
        LOOPBACK = 2'd3
    } test_mode_e;

    // Register write, held stable while req is high
    typedef struct packed
    {
        logic [3:0]  addr;
        logic [31:0] wdata;   // [1:0] mode, [31:2] count
    } csr_wr_t;

    // Decoded command, valid for one cycle
    typedef struct packed
    {
        logic        valid;
        test_mode_e  mode;
        logic [29:0] count;
    } test_cmd_t;

    // Monitor status
    typedef struct packed
    {
        test_mode_e  mode;
        logic [15:0] msg_count;   // Saturates
        logic [7:0]  tests_done;  // Wraps
        test_mode_e  last_mode;
        logic [5:0]  rsvd;
    } test_status_t;

endpackage

// File: design/csr_decode.sv
/*
 * Four-phase register slave for the test command.
 * Acknowledges every write and, for a write to the test address, emits a
 * one-cycle command in the cycle that ack rises. SOURCE with count 0 is
 * acknowledged and dropped.
 */
`timescale 1ns/1ns
`include "chan_test_cfg.svh"

module csr_decode
(
    input  logic                   clk,
    input  logic                   resetb,
    input  logic                   csr_req,
    input  chan_test_pkg::csr_wr_t csr_wr,
    output logic                   csr_ack,
    output chan_test_pkg::test_cmd_t cmd
);

    // Fields of the incoming write
    chan_test_pkg::test_mode_e wr_mode;
    logic [29:0]               wr_count;
    logic                      addr_hit;
    logic                      src_zero;
    logic                      accept;

    // Command register, valid bit is control and the rest is payload
    logic                      cmd_valid;
    chan_test_pkg::test_mode_e cmd_mode;
    logic [29:0]               cmd_count;

    assign wr_mode  = chan_test_pkg::test_mode_e'(csr_wr.wdata[1:0]);
    assign wr_count = csr_wr.wdata[31:2];
    assign addr_hit = (csr_wr.addr == 4'(`CSR_TEST_ADDR));

    // A zero-length source run would wrap the generator
    assign src_zero = (wr_mode == chan_test_pkg::SOURCE) && (wr_count == 30'd0);

    // New request seen while ack is still low
    assign accept = csr_req && !csr_ack;

    // Handshake and command strobe
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            csr_ack   <= 1'b0;
            cmd_valid <= 1'b0;
        end
        else
        begin
            // Strobe lasts one cycle at most
            cmd_valid <= 1'b0;
            if (accept)
            begin
                csr_ack   <= 1'b1;
                cmd_valid <= addr_hit && !src_zero;
            end
            else if (!csr_req && csr_ack)
            begin
                // Master released req, close the handshake
                csr_ack <= 1'b0;
            end
        end
    end

    // Command payload captured with the request
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            cmd_mode  <= wr_mode;
            cmd_count <= wr_count;
        end
    end

    assign cmd.valid = cmd_valid;
    assign cmd.mode  = cmd_mode;
    assign cmd.count = cmd_count;

endmodule

// File: design/chan_test_mux.sv
/*
 * Mode FSM and data router between the client FIFOs and the host driver.
 * NORMAL connects both sides straight through. SINK, SOURCE and LOOPBACK
 * cut the client off and talk to the host. A test ends on a message with
 * bit 0 set, or when the source count runs out, and the mode returns to
 * NORMAL in the next clock.
 */
`timescale 1ns/1ns
`include "chan_test_cfg.svh"

module chan_test_mux
(
    input  logic                        clk,
    input  logic                        resetb,
    input  chan_test_pkg::test_cmd_t    cmd,

    // To the client
    output chan_test_pkg::chan_data_t   rx_fifo_data,
    output logic                        rx_fifo_rdy,
    input  logic                        rx_fifo_enable,

    // From the client
    input  chan_test_pkg::chan_data_t   tx_fifo_data,
    output logic                        tx_fifo_rdy,
    input  logic                        tx_fifo_enable,

    // From the host
    input  chan_test_pkg::chan_data_t   rx_data,
    input  logic                        rx_rdy,
    output logic                        rx_enable,

    // To the host
    output chan_test_pkg::chan_data_t   tx_data,
    input  logic                        tx_rdy,
    output logic                        tx_enable,

    output chan_test_pkg::test_mode_e   mode,
    output logic                        test_done
);

    // Step constant of the source sequence at full width
    localparam chan_test_pkg::chan_data_t SRC_STEP = `CHAN_WIDTH'(`SRC_MIX);

    // Single message sent when a sink test ends
    localparam chan_test_pkg::chan_data_t SINK_END = `CHAN_WIDTH'(1);

    // Source generator
    chan_test_pkg::chan_data_t source_data;
    logic [29:0]               source_count;
    logic                      src_last;

    // Last message of the run
    assign src_last = (source_count == 30'd1);

    // Routing, rdy to enable within the cycle
    always_comb
    begin
        // Straight-through by default
        rx_fifo_data = rx_data;
        rx_fifo_rdy  = rx_rdy;
        rx_enable    = rx_fifo_enable;
        tx_data      = tx_fifo_data;
        tx_fifo_rdy  = tx_rdy;
        tx_enable    = tx_fifo_enable;
        test_done    = 1'b0;

        case (mode)
            chan_test_pkg::SINK:
            begin
                // Client sees no rdy on either side
                rx_fifo_rdy = 1'b0;
                tx_fifo_rdy = 1'b0;
                // Take a host message only if the end reply could go out
                rx_enable   = rx_rdy && tx_rdy;
                test_done   = rx_enable && rx_data[0];
                // One reply of value 1 when the test ends
                tx_data     = SINK_END;
                tx_enable   = test_done;
            end

            chan_test_pkg::SOURCE:
            begin
                rx_fifo_rdy = 1'b0;
                tx_fifo_rdy = 1'b0;
                // Host traffic is drained
                rx_enable   = rx_rdy;
                // Bit 0 carries the last-message flag
                tx_data     = {source_data[`CHAN_WIDTH-1:1], src_last};
                tx_enable   = tx_rdy;
                test_done   = tx_rdy && src_last;
            end

            chan_test_pkg::LOOPBACK:
            begin
                rx_fifo_rdy = 1'b0;
                tx_fifo_rdy = 1'b0;
                // Accept only what can be echoed in the same cycle
                rx_enable   = rx_rdy && tx_rdy;
                test_done   = rx_enable && rx_data[0];
                tx_data     = rx_data;
                tx_enable   = rx_enable;
            end

            default:
            begin
                // NORMAL keeps the defaults
            end
        endcase
    end

    // Mode register, a new command beats test_done
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            mode <= chan_test_pkg::NORMAL;
        end
        else if (cmd.valid)
        begin
            mode <= cmd.mode;
        end
        else if (test_done)
        begin
            mode <= chan_test_pkg::NORMAL;
        end
    end

    // Remaining source messages
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            source_count <= 30'd0;
        end
        else if (cmd.valid)
        begin
            source_count <= cmd.count;
        end
        else if (mode == chan_test_pkg::SOURCE && tx_rdy)
        begin
            source_count <= source_count - 30'd1;
        end
    end

    // Sequence value, restarts at 1 on every command
    always_ff @(posedge clk)
    begin
        if (cmd.valid)
        begin
            source_data <= `CHAN_WIDTH'(1);
        end
        else if (mode == chan_test_pkg::SOURCE && tx_rdy)
        begin
            // Shift and mix, advances only when a message leaves
            source_data <= (source_data << 1) ^ SRC_STEP;
        end
    end

endmodule

// File: design/test_monitor.sv
/*
 * Status counters for the test harness.
 * Counts messages sent to the host while a test runs, counts finished
 * tests and keeps the mode of the last one. Counters lag the event by
 * one clock, the current mode is passed straight through.
 */
`timescale 1ns/1ns

module test_monitor
(
    input  logic                        clk,
    input  logic                        resetb,
    input  chan_test_pkg::test_mode_e   mode,
    input  logic                        test_done,
    input  logic                        tx_enable,
    output chan_test_pkg::test_status_t status
);

    logic [15:0]               msg_count;
    logic [7:0]                tests_done;
    chan_test_pkg::test_mode_e last_mode;
    logic                      in_test;

    assign in_test = (mode != chan_test_pkg::NORMAL);

    // Host-bound messages during tests, saturating
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            msg_count <= 16'd0;
        end
        else if (in_test && tx_enable && msg_count != 16'hffff)
        begin
            msg_count <= msg_count + 16'd1;
        end
    end

    // Finished tests and their mode
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            tests_done <= 8'd0;
            last_mode  <= chan_test_pkg::NORMAL;
        end
        else if (test_done)
        begin
            // Wraps at 256
            tests_done <= tests_done + 8'd1;
            last_mode  <= mode;
        end
    end

    assign status.mode       = mode;
    assign status.msg_count  = msg_count;
    assign status.tests_done = tests_done;
    assign status.last_mode  = last_mode;
    assign status.rsvd       = 6'd0;

endmodule

// File: design/chan_test_top.sv
/*
 * Top level of the channel test harness.
 * Sits between the client FIFO ports and the host driver FIFO ports.
 * A register write picks the test mode, status shows the monitor counters.
 */
`timescale 1ns/1ns

module chan_test_top
(
    input  logic                        clk,
    input  logic                        resetb,

    // Register write port, four-phase
    input  logic                        csr_req,
    input  chan_test_pkg::csr_wr_t      csr_wr,
    output logic                        csr_ack,

    // Client side
    output chan_test_pkg::chan_data_t   rx_fifo_data,
    output logic                        rx_fifo_rdy,
    input  logic                        rx_fifo_enable,
    input  chan_test_pkg::chan_data_t   tx_fifo_data,
    output logic                        tx_fifo_rdy,
    input  logic                        tx_fifo_enable,

    // Driver side
    input  chan_test_pkg::chan_data_t   rx_data,
    input  logic                        rx_rdy,
    output logic                        rx_enable,
    output chan_test_pkg::chan_data_t   tx_data,
    input  logic                        tx_rdy,
    output logic                        tx_enable,

    output chan_test_pkg::test_status_t status
);

    chan_test_pkg::test_cmd_t  cmd;
    chan_test_pkg::test_mode_e mode;
    logic                      test_done;

    csr_decode u_csr_decode
    (
        .clk       (clk),
        .resetb    (resetb),
        .csr_req   (csr_req),
        .csr_wr    (csr_wr),
        .csr_ack   (csr_ack),
        .cmd       (cmd)
    );

    chan_test_mux u_chan_test_mux
    (
        .clk            (clk),
        .resetb         (resetb),
        .cmd            (cmd),
        .rx_fifo_data   (rx_fifo_data),
        .rx_fifo_rdy    (rx_fifo_rdy),
        .rx_fifo_enable (rx_fifo_enable),
        .tx_fifo_data   (tx_fifo_data),
        .tx_fifo_rdy    (tx_fifo_rdy),
        .tx_fifo_enable (tx_fifo_enable),
        .rx_data        (rx_data),
        .rx_rdy         (rx_rdy),
        .rx_enable      (rx_enable),
        .tx_data        (tx_data),
        .tx_rdy         (tx_rdy),
        .tx_enable      (tx_enable),
        .mode           (mode),
        .test_done      (test_done)
    );

    test_monitor u_test_monitor
    (
        .clk       (clk),
        .resetb    (resetb),
        .mode      (mode),
        .test_done (test_done),
        .tx_enable (tx_enable),
        .status    (status)
    );

endmodule

// File: tb/chan_test_sva.sv
/*
 * Assertions on the register handshake and the routing rules.
 * Bound into the top level so the decode and mux signals are both visible.
 * The failure count is read by the testbench for its final verdict.
 */
`timescale 1ns/1ns

module chan_test_sva
(
    input logic                      clk,
    input logic                      resetb,
    input logic                      csr_req,
    input logic                      csr_ack,
    input chan_test_pkg::test_cmd_t  cmd,
    input chan_test_pkg::test_mode_e mode,
    input logic                      rx_fifo_rdy,
    input logic                      tx_fifo_rdy,
    input logic                      tx_enable,
    input logic                      tx_fifo_enable
);

    int fail_count = 0;

    // Client is cut off in every test mode
    client_rdy_low: assert property (@(posedge clk) disable iff (!resetb)
        (mode != chan_test_pkg::NORMAL) |-> (!rx_fifo_rdy && !tx_fifo_rdy))
    else
    begin
        fail_count++;
        $error("client rdy high outside NORMAL");
    end

    // Ack holds while the master still has req up
    ack_hold: assert property (@(posedge clk) disable iff (!resetb)
        (csr_req && csr_ack) |=> csr_ack)
    else
    begin
        fail_count++;
        $error("csr_ack fell while csr_req was high");
    end

    // Command strobe is a single cycle
    cmd_pulse: assert property (@(posedge clk) disable iff (!resetb)
        cmd.valid |=> !cmd.valid)
    else
    begin
        fail_count++;
        $error("command valid for more than one cycle");
    end

    // Straight-through to the host in NORMAL
    normal_tx: assert property (@(posedge clk) disable iff (!resetb)
        (mode == chan_test_pkg::NORMAL) |-> (tx_enable == tx_fifo_enable))
    else
    begin
        fail_count++;
        $error("tx_enable differs from tx_fifo_enable in NORMAL");
    end

endmodule

bind chan_test_top chan_test_sva u_sva
(
    .clk            (clk),
    .resetb         (resetb),
    .csr_req        (csr_req),
    .csr_ack        (csr_ack),
    .cmd            (cmd),
    .mode           (mode),
    .rx_fifo_rdy    (rx_fifo_rdy),
    .tx_fifo_rdy    (tx_fifo_rdy),
    .tx_enable      (tx_enable),
    .tx_fifo_enable (tx_fifo_enable)
);

// File: tb/chan_test_tb.sv
/*
 * Testbench for the channel test harness.
 * Drives random client and host traffic on the falling edge, checks routing
 * and host-bound data on the rising edge against the mode rules, and runs
 * the pass-through, loopback, sink, source and register tests in sequence.
 */
`timescale 1ns/1ns
`include "chan_test_cfg.svh"

module chan_test_tb;

    // Traffic lengths per test
    localparam int NORMAL_LEN = 400;
    localparam int LOOP_LEN   = 300;
    localparam int SINK_LEN   = 300;
    localparam int SRC_N      = 50;
    // Twice the traffic plus slack for the register writes
    localparam int MAX_CYCLES = 2 * (NORMAL_LEN + LOOP_LEN + SINK_LEN + 4 * SRC_N) + 1600;
    localparam int CSR_WAIT   = 8;

    logic                        clk = 1'b0;
    logic                        resetb;
    logic                        csr_req;
    chan_test_pkg::csr_wr_t      csr_wr;
    logic                        csr_ack;
    chan_test_pkg::chan_data_t   rx_fifo_data;
    logic                        rx_fifo_rdy;
    logic                        rx_fifo_enable;
    chan_test_pkg::chan_data_t   tx_fifo_data;
    logic                        tx_fifo_rdy;
    logic                        tx_fifo_enable;
    chan_test_pkg::chan_data_t   rx_data;
    logic                        rx_rdy;
    logic                        rx_enable;
    chan_test_pkg::chan_data_t   tx_data;
    logic                        tx_rdy;
    logic                        tx_enable;
    chan_test_pkg::test_status_t status;

    integer seed;
    int     cycles = 0;
    int     seq_errors = 0;
    int     cmp_errors = 0;

    // A new test is armed for the comparator by bumping arm_count
    chan_test_pkg::test_mode_e next_mode = chan_test_pkg::NORMAL;
    int                        next_src_n = 0;
    int                        arm_count = 0;

    // Comparator state
    chan_test_pkg::test_mode_e exp_mode = chan_test_pkg::NORMAL;
    chan_test_pkg::test_mode_e last_mode_exp = chan_test_pkg::NORMAL;
    chan_test_pkg::chan_data_t exp_data;
    int                        arm_seen = 0;
    int                        src_n = 0;
    int                        src_idx = 0;
    int                        tests_exp = 0;
    int                        host_sent = 0;
    int                        normal_moves = 0;
    logic                      host_take;
    logic                      end_now;

    chan_test_top dut
    (
        .clk            (clk),
        .resetb         (resetb),
        .csr_req        (csr_req),
        .csr_wr         (csr_wr),
        .csr_ack        (csr_ack),
        .rx_fifo_data   (rx_fifo_data),
        .rx_fifo_rdy    (rx_fifo_rdy),
        .rx_fifo_enable (rx_fifo_enable),
        .tx_fifo_data   (tx_fifo_data),
        .tx_fifo_rdy    (tx_fifo_rdy),
        .tx_fifo_enable (tx_fifo_enable),
        .rx_data        (rx_data),
        .rx_rdy         (rx_rdy),
        .rx_enable      (rx_enable),
        .tx_data        (tx_data),
        .tx_rdy         (tx_rdy),
        .tx_enable      (tx_enable),
        .status         (status)
    );

    always #2 clk = ~clk;

    // Expected i-th source message with bit 0 flagging the last of total
    function automatic chan_test_pkg::chan_data_t ref_source(input int idx, input int total);
        chan_test_pkg::chan_data_t value;
        value = `CHAN_WIDTH'(1);
        for (int k = 0; k < idx; k++)
        begin
            value = (value << 1) ^ `CHAN_WIDTH'(`SRC_MIX);
        end
        value[0] = (idx == total - 1);
        return value;
    endfunction

    function automatic int total_errors();
        return seq_errors + cmp_errors + dut.u_sva.fail_count;
    endfunction

    task automatic check_data(input string name, input chan_test_pkg::chan_data_t got,
                              input chan_test_pkg::chan_data_t exp, inout int errs);
        if (got !== exp)
        begin
            errs++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp,
                              inout int errs);
        if (got !== exp)
        begin
            errs++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_mode(input string name, input chan_test_pkg::test_mode_e got,
                              input chan_test_pkg::test_mode_e exp, inout int errs);
        if (got !== exp)
        begin
            errs++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_status(input string name, input chan_test_pkg::test_status_t got,
                                input chan_test_pkg::test_status_t exp, inout int errs);
        if (got !== exp)
        begin
            errs++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    // Ending message seen and the DUT goes back to NORMAL next clock
    task automatic close_test();
        last_mode_exp = exp_mode;
        tests_exp++;
        exp_mode = chan_test_pkg::NORMAL;
    endtask

    // Rising-edge comparator
    always @(posedge clk)
    begin
        if (arm_count != arm_seen)
        begin
            arm_seen = arm_count;
            exp_mode = next_mode;
            src_n    = next_src_n;
            src_idx  = 0;
        end
        host_take = rx_rdy && tx_rdy;
        if (resetb && exp_mode == chan_test_pkg::NORMAL)
        begin
            check_flag("rx_fifo_rdy", rx_fifo_rdy, rx_rdy, cmp_errors);
            check_flag("tx_fifo_rdy", tx_fifo_rdy, tx_rdy, cmp_errors);
            check_flag("rx_enable", rx_enable, rx_fifo_enable, cmp_errors);
            check_flag("tx_enable", tx_enable, tx_fifo_enable, cmp_errors);
            if (rx_rdy && rx_fifo_enable)
            begin
                check_data("rx_fifo_data", rx_fifo_data, rx_data, cmp_errors);
                normal_moves++;
            end
            if (tx_rdy && tx_fifo_enable)
            begin
                check_data("tx_data", tx_data, tx_fifo_data, cmp_errors);
                normal_moves++;
            end
        end
        else if (resetb)
        begin
            check_flag("rx_fifo_rdy", rx_fifo_rdy, 1'b0, cmp_errors);
            check_flag("tx_fifo_rdy", tx_fifo_rdy, 1'b0, cmp_errors);
            case (exp_mode)
                chan_test_pkg::LOOPBACK:
                begin
                    // Echo in the same cycle and only with both rdy high
                    check_flag("rx_enable", rx_enable, host_take, cmp_errors);
                    check_flag("tx_enable", tx_enable, host_take, cmp_errors);
                    if (host_take)
                    begin
                        check_data("tx_data", tx_data, rx_data, cmp_errors);
                        host_sent++;
                        if (rx_data[0])
                            close_test();
                    end
                end
                chan_test_pkg::SINK:
                begin
                    // Silent until the ending message and then one reply of 1
                    end_now = host_take && rx_data[0];
                    check_flag("rx_enable", rx_enable, host_take, cmp_errors);
                    check_flag("tx_enable", tx_enable, end_now, cmp_errors);
                    if (end_now)
                    begin
                        check_data("tx_data", tx_data, `CHAN_WIDTH'(1), cmp_errors);
                        host_sent++;
                        close_test();
                    end
                end
                chan_test_pkg::SOURCE:
                begin
                    check_flag("tx_enable", tx_enable, tx_rdy, cmp_errors);
                    if (tx_rdy)
                    begin
                        exp_data = ref_source(src_idx, src_n);
                        check_data("tx_data", tx_data, exp_data, cmp_errors);
                        src_idx++;
                        host_sent++;
                        if (src_idx == src_n)
                            close_test();
                    end
                end
                default:
                begin
                end
            endcase
        end
    end

    // Run limit
    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
        begin
            $display("Timeout: no finish after %0d cycles", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic drive_random(input logic force_bit, input logic bit_val);
        @(negedge clk);
        rx_rdy         = 1'($random(seed));
        tx_rdy         = 1'($random(seed));
        rx_fifo_enable = 1'($random(seed));
        tx_fifo_enable = 1'($random(seed));
        rx_data        = `CHAN_WIDTH'({$random(seed), $random(seed)});
        tx_fifo_data   = `CHAN_WIDTH'({$random(seed), $random(seed)});
        if (force_bit)
            rx_data[0] = bit_val;
    endtask

    task automatic set_idle();
        @(negedge clk);
        rx_rdy         = 1'b0;
        tx_rdy         = 1'b0;
        rx_fifo_enable = 1'b0;
        tx_fifo_enable = 1'b0;
        rx_data        = '0;
        tx_fifo_data   = '0;
    endtask

    // Full four-phase write that returns once ack is low again
    task automatic csr_write(input logic [3:0] addr, input logic [31:0] wdata);
        int wait_cyc;
        @(negedge clk);
        csr_wr.addr  = addr;
        csr_wr.wdata = wdata;
        csr_req      = 1'b1;
        @(negedge clk);
        wait_cyc = 1;
        while (!csr_ack && wait_cyc < CSR_WAIT)
        begin
            @(negedge clk);
            wait_cyc++;
        end
        if (!csr_ack)
        begin
            seq_errors++;
            $display("Register write to %h was never acknowledged", addr);
        end
        csr_req = 1'b0;
        @(negedge clk);
        wait_cyc = 1;
        while (csr_ack && wait_cyc < CSR_WAIT)
        begin
            @(negedge clk);
            wait_cyc++;
        end
        if (csr_ack)
        begin
            seq_errors++;
            $display("Register ack stayed high after req was dropped");
        end
    endtask

    task automatic start_test(input chan_test_pkg::test_mode_e m, input int count);
        set_idle();
        csr_write(4'(`CSR_TEST_ADDR), {30'(count), m});
        check_mode("status.mode", status.mode, m, seq_errors);
        next_mode  = m;
        next_src_n = count;
        arm_count++;
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        if (total_errors() == errs_before)
            $display("Test %0d %s: ok", num, name);
        else
            $display("Test %0d %s: %0d errors", num, name, total_errors() - errs_before);
    endtask

    initial
    begin
        int errs;
        int done_before;
        chan_test_pkg::test_status_t exp_st;
        seed    = 32'hcb53_e42a;
        resetb  = 1'b0;
        csr_req = 1'b0;
        csr_wr  = '0;
        rx_rdy         = 1'b0;
        tx_rdy         = 1'b0;
        rx_fifo_enable = 1'b0;
        tx_fifo_enable = 1'b0;
        rx_data        = '0;
        tx_fifo_data   = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        resetb = 1'b1;
        @(negedge clk);
        exp_st = '0;
        check_status("status", status, exp_st, seq_errors);
        check_flag("csr_ack", csr_ack, 1'b0, seq_errors);

        errs = total_errors();
        repeat (NORMAL_LEN) drive_random(1'b0, 1'b0);
        report_test(1, "normal pass-through", errs);

        // Echo, then an ending message, then client traffic again
        errs = total_errors();
        done_before = tests_exp;
        start_test(chan_test_pkg::LOOPBACK, 0);
        repeat (LOOP_LEN) drive_random(1'b1, 1'b0);
        while (tests_exp == done_before)
            drive_random(1'b1, 1'b1);
        set_idle();
        check_mode("status.mode", status.mode, chan_test_pkg::NORMAL, seq_errors);
        repeat (20) drive_random(1'b0, 1'b0);
        report_test(2, "loopback", errs);

        errs = total_errors();
        done_before = tests_exp;
        start_test(chan_test_pkg::SINK, 0);
        repeat (SINK_LEN) drive_random(1'b1, 1'b0);
        while (tests_exp == done_before)
            drive_random(1'b1, 1'b1);
        set_idle();
        check_mode("status.mode", status.mode, chan_test_pkg::NORMAL, seq_errors);
        report_test(3, "sink", errs);

        // Counted run followed by a zero count that must be dropped
        errs = total_errors();
        done_before = tests_exp;
        start_test(chan_test_pkg::SOURCE, SRC_N);
        while (tests_exp == done_before)
            drive_random(1'b0, 1'b0);
        set_idle();
        check_mode("status.mode", status.mode, chan_test_pkg::NORMAL, seq_errors);
        csr_write(4'(`CSR_TEST_ADDR), {30'd0, chan_test_pkg::SOURCE});
        repeat (20) drive_random(1'b0, 1'b0);
        check_mode("status.mode", status.mode, chan_test_pkg::NORMAL, seq_errors);
        report_test(4, "source", errs);

        // Status from the model before and after a write to a foreign address
        errs = total_errors();
        set_idle();
        exp_st.mode       = chan_test_pkg::NORMAL;
        exp_st.msg_count  = 16'(host_sent);
        exp_st.tests_done = 8'(tests_exp);
        exp_st.last_mode  = last_mode_exp;
        exp_st.rsvd       = '0;
        check_status("status", status, exp_st, seq_errors);
        csr_write(4'd5, {30'd7, chan_test_pkg::LOOPBACK});
        repeat (5) set_idle();
        check_status("status", status, exp_st, seq_errors);
        report_test(5, "status and register port", errs);

        $display("Tests 5, host messages %0d, normal moves %0d, errors %0d",
                 host_sent, normal_moves, total_errors());
        if (total_errors() == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+design
design/chan_test_pkg.sv
design/csr_decode.sv
design/chan_test_mux.sv
design/test_monitor.sv
design/chan_test_top.sv
tb/chan_test_sva.sv
tb/chan_test_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the channel test harness testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module chan_test_tb \
    -f verilog.f -o chan_test_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Keep running past assertion errors so the testbench gives the verdict
output=$(./obj_dir/chan_test_sim +verilator+error+limit+1000)
sim_status=$?
echo "$output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$output" | grep -q "^RESULT: PASS$"; then
    exit 0
fi
exit 1
